// File: src/knightTour_cfg.svh
`ifndef KNIGHT_TOUR_CFG_SVH
`define KNIGHT_TOUR_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Serial line timing
//////////////////////////////////////////////////////////////////////

// Clock cycles per serial bit, used for both receive and transmit
`define BAUD_DIV 16

//////////////////////////////////////////////////////////////////////
// Motion timing and board geometry
//////////////////////////////////////////////////////////////////////

// A move lasts this many cycles for every square travelled
`define SQUARE_CYCLES 200
// Gyro calibration is modelled as a fixed delay
`define CAL_CYCLES 300
// The board is square, so one size covers both axes
`define BOARD_SIZE 5

`endif

// File: src/knightSerialPkg.sv
package knightSerialPkg;

  // One character on the serial line carries a single data byte
  typedef logic [7:0] serialByte_t;

  // Index of the data bit currently on the line, LSB goes first
  typedef logic [2:0] bitIdx_t;

  // Both UARTs walk through the same four phases of a character
  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uartState_t;

  // The line rests high between characters
  localparam logic LINE_IDLE = 1'b1;

  // Start bit is low and stop bit is high
  localparam logic START_BIT = 1'b0;
  localparam logic STOP_BIT = 1'b1;

endpackage

// File: src/knightCmdPkg.sv
package knightCmdPkg;

  //////////////////////////////////////////////////////////////////////
  // Command fields
  //////////////////////////////////////////////////////////////////////

  // Any opcode other than the two below is rejected
  typedef logic [3:0] cmdOp_t;
  localparam cmdOp_t OP_CALIBRATE = 4'h2;
  localparam cmdOp_t OP_MOVE = 4'h4;

  // Headings are coarse compass values from the remote station
  typedef logic [7:0] heading_t;
  localparam heading_t HEAD_NORTH = 8'h00;
  localparam heading_t HEAD_WEST = 8'h3F;
  localparam heading_t HEAD_SOUTH = 8'h7F;
  localparam heading_t HEAD_EAST = 8'hBF;

  // High byte holds opcode and the upper heading nibble, low byte the rest
  typedef struct packed {
    cmdOp_t op;
    heading_t heading;
    logic [3:0] squares;
  } knightCmd_t;

  //////////////////////////////////////////////////////////////////////
  // Board position and answers
  //////////////////////////////////////////////////////////////////////

  // West lowers x and east raises it, north raises y and south lowers it
  typedef struct packed {
    logic [2:0] x;
    logic [2:0] y;
  } boardPos_t;

  // The knight starts in the centre square
  localparam boardPos_t POS_HOME = '{x: 3'd2, y: 3'd2};

  typedef logic [7:0] respCode_t;
  localparam respCode_t RESP_ACK = 8'hA5;
  localparam respCode_t RESP_NACK = 8'h5A;

endpackage

// File: src/uartRx.sv
`timescale 1ns/100ps
`include "knightTour_cfg.svh"

module uartRx import knightSerialPkg::*; (
  input logic clk,
  input logic rstN,
  input logic rx,
  output serialByte_t rxByte,
  output logic rxValid
);

  localparam int CntW = $clog2(`BAUD_DIV);
  localparam int HalfBit = `BAUD_DIV / 2;

  logic rxMeta;
  logic rxSync;
  uartState_t state;
  logic [CntW-1:0] bitCnt;
  bitIdx_t bitIdx;
  serialByte_t shiftReg;
  logic bitEnd;

  // The rx line comes from outside, so it passes two flops first
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rxMeta <= LINE_IDLE;
      rxSync <= LINE_IDLE;
    end else begin
      rxMeta <= rx;
      rxSync <= rxMeta;
    end
  end

  // Once the start bit centre is found, a full bit time lands mid-bit
  assign bitEnd = (bitCnt == CntW'(`BAUD_DIV - 1));

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= UART_IDLE;
      bitCnt <= '0;
      bitIdx <= '0;
      rxValid <= 1'b0;
    end else begin
      rxValid <= 1'b0;
      case (state)
        UART_IDLE: begin
          bitCnt <= '0;
          if (rxSync == START_BIT) state <= UART_START;
        end
        UART_START: begin
          // Recheck at the centre of the start bit to reject glitches
          if (bitCnt == CntW'(HalfBit - 1)) begin
            bitCnt <= '0;
            bitIdx <= '0;
            state <= (rxSync == START_BIT) ? UART_DATA : UART_IDLE;
          end else begin
            bitCnt <= bitCnt + 1'b1;
          end
        end
        UART_DATA: begin
          bitCnt <= bitEnd ? '0 : bitCnt + 1'b1;
          if (bitEnd) begin
            if (bitIdx == 3'd7) state <= UART_STOP;
            bitIdx <= bitIdx + 1'b1;
          end
        end
        default: begin
          // A framing error (low stop bit) drops the character silently
          if (bitEnd) begin
            bitCnt <= '0;
            rxValid <= (rxSync == STOP_BIT);
            state <= UART_IDLE;
          end else begin
            bitCnt <= bitCnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Bits arrive LSB first, so each new one enters at the top
  always_ff @(posedge clk) begin
    if (state == UART_DATA && bitEnd) shiftReg <= {rxSync, shiftReg[7:1]};
  end

  assign rxByte = shiftReg;

endmodule

// File: src/uartTx.sv
`timescale 1ns/100ps
`include "knightTour_cfg.svh"

module uartTx import knightSerialPkg::*, knightCmdPkg::*; (
  input logic clk,
  input logic rstN,
  input respCode_t resp,
  input logic respValid,
  output logic respReady,
  output logic tx
);

  localparam int CntW = $clog2(`BAUD_DIV);

  uartState_t state;
  logic [CntW-1:0] bitCnt;
  bitIdx_t bitIdx;
  serialByte_t shiftReg;
  logic bitEnd;
  logic load;

  // New bytes are taken only between characters
  assign respReady = (state == UART_IDLE);
  assign load = respValid && respReady;
  assign bitEnd = (bitCnt == CntW'(`BAUD_DIV - 1));

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= UART_IDLE;
      bitCnt <= '0;
      bitIdx <= '0;
      tx <= LINE_IDLE;
    end else begin
      bitCnt <= (state == UART_IDLE || bitEnd) ? '0 : bitCnt + 1'b1;
      case (state)
        UART_IDLE: begin
          if (load) begin
            tx <= START_BIT;
            state <= UART_START;
          end
        end
        UART_START: begin
          bitIdx <= '0;
          if (bitEnd) begin
            tx <= shiftReg[0];
            state <= UART_DATA;
          end
        end
        UART_DATA: begin
          if (bitEnd) begin
            // Ones fill the register behind the data, so bit 0 is the stop bit last
            tx <= shiftReg[0];
            bitIdx <= bitIdx + 1'b1;
            if (bitIdx == 3'd7) state <= UART_STOP;
          end
        end
        default: begin
          if (bitEnd) state <= UART_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      shiftReg <= resp;
    end else if ((state == UART_START || state == UART_DATA) && bitEnd) begin
      shiftReg <= {STOP_BIT, shiftReg[7:1]};
    end
  end

endmodule

// File: src/cmdFramer.sv
`timescale 1ns/100ps
`include "knightTour_cfg.svh"

module cmdFramer import knightSerialPkg::*, knightCmdPkg::*; (
  input logic clk,
  input logic rstN,
  input serialByte_t rxByte,
  input logic rxValid,
  output knightCmd_t cmd,
  output logic cmdValid,
  input logic cmdReady
);

  // A lone high byte is given up after four character times of silence
  localparam int TimeoutCycles = 4 * 10 * `BAUD_DIV;
  localparam int ToW = $clog2(TimeoutCycles);

  typedef enum logic [1:0] {FR_EMPTY, FR_HIGH, FR_FULL} frameState_t;

  frameState_t state;
  logic [ToW-1:0] gapCnt;
  serialByte_t hiByte;
  knightCmd_t cmdReg;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= FR_EMPTY;
      gapCnt <= '0;
    end else begin
      case (state)
        FR_EMPTY: begin
          gapCnt <= '0;
          if (rxValid) state <= FR_HIGH;
        end
        FR_HIGH: begin
          gapCnt <= gapCnt + 1'b1;
          if (rxValid) state <= FR_FULL;
          else if (gapCnt == ToW'(TimeoutCycles - 1)) state <= FR_EMPTY;
        end
        default: begin
          // Bytes that arrive while a command waits are lost
          if (cmdReady) state <= FR_EMPTY;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rxValid && state == FR_EMPTY) hiByte <= rxByte;
    if (rxValid && state == FR_HIGH) cmdReg <= {hiByte, rxByte};
  end

  assign cmd = cmdReg;
  assign cmdValid = (state == FR_FULL);

endmodule

// File: src/moveSequencer.sv
`timescale 1ns/100ps
`include "knightTour_cfg.svh"

module moveSequencer import knightCmdPkg::*; (
  input logic clk,
  input logic rstN,
  input knightCmd_t cmd,
  input logic cmdValid,
  output logic cmdReady,
  output respCode_t resp,
  output logic respValid,
  input logic respReady,
  output boardPos_t pos,
  output logic busy
);

  // The longest wait is either calibration or a fifteen square move
  localparam int MaxMove = 15 * `SQUARE_CYCLES;
  localparam int MaxDur = (MaxMove > `CAL_CYCLES) ? MaxMove : `CAL_CYCLES;
  localparam int DurW = $clog2(MaxDur);

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_CAL, SEQ_MOVE, SEQ_RESP} seqState_t;

  seqState_t state;
  logic [DurW-1:0] durCnt;
  logic calibrated;
  boardPos_t posReg;
  boardPos_t posTarget;
  respCode_t respReg;
  logic accept;
  logic headingOk;
  logic signed [5:0] stepX;
  logic signed [5:0] stepY;
  logic signed [5:0] sqCount;
  logic signed [5:0] destX;
  logic signed [5:0] destY;
  logic onBoard;
  logic moveOk;

  //////////////////////////////////////////////////////////////////////
  // Command decode and destination check
  //////////////////////////////////////////////////////////////////////

  // Each legal heading maps to a unit step on one axis
  always_comb begin
    stepX = '0;
    stepY = '0;
    headingOk = 1'b1;
    case (cmd.heading)
      HEAD_NORTH: stepY = 6'sd1;
      HEAD_SOUTH: stepY = -6'sd1;
      HEAD_WEST: stepX = -6'sd1;
      HEAD_EAST: stepX = 6'sd1;
      default: headingOk = 1'b0;
    endcase
  end

  assign sqCount = $signed({2'b00, cmd.squares});
  assign destX = $signed({3'b000, posReg.x}) + stepX * sqCount;
  assign destY = $signed({3'b000, posReg.y}) + stepY * sqCount;
  assign onBoard = (destX >= 0) && (destX < `BOARD_SIZE) &&
                   (destY >= 0) && (destY < `BOARD_SIZE);

  // Moves need a calibrated gyro, a real heading, a distance and room to land
  assign moveOk = (cmd.op == OP_MOVE) && calibrated && headingOk &&
                  (cmd.squares != 4'd0) && onBoard;

  assign accept = cmdValid && cmdReady;

  //////////////////////////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= SEQ_IDLE;
      durCnt <= '0;
      calibrated <= 1'b0;
      posReg <= POS_HOME;
      respReg <= RESP_NACK;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (accept) begin
            if (cmd.op == OP_CALIBRATE) begin
              durCnt <= DurW'(`CAL_CYCLES - 1);
              state <= SEQ_CAL;
            end else if (moveOk) begin
              durCnt <= DurW'(cmd.squares * `SQUARE_CYCLES - 1);
              state <= SEQ_MOVE;
            end else begin
              // Rejected commands answer straight away
              respReg <= RESP_NACK;
              state <= SEQ_RESP;
            end
          end
        end
        SEQ_CAL, SEQ_MOVE: begin
          durCnt <= durCnt - 1'b1;
          if (durCnt == '0) begin
            if (state == SEQ_CAL) calibrated <= 1'b1;
            // The knight lands on its target in one step
            else posReg <= posTarget;
            respReg <= RESP_ACK;
            state <= SEQ_RESP;
          end
        end
        default: begin
          if (respReady) state <= SEQ_IDLE;
        end
      endcase
    end
  end

  // Destination is captured at accept because cmd may change afterwards
  always_ff @(posedge clk) begin
    if (accept && moveOk) posTarget <= '{x: destX[2:0], y: destY[2:0]};
  end

  assign cmdReady = (state == SEQ_IDLE);
  assign busy = (state == SEQ_CAL) || (state == SEQ_MOVE);
  assign respValid = (state == SEQ_RESP);
  assign resp = respReg;
  assign pos = posReg;

endmodule

// File: src/knightTour.sv
`timescale 1ns/100ps

module knightTour import knightSerialPkg::*, knightCmdPkg::*; (
  input logic clk,
  input logic rstN,
  input logic rx,
  output logic tx,
  output boardPos_t pos,
  output logic busy
);

  // Received bytes toward the framer
  serialByte_t rxByte;
  logic rxValid;

  // Framed commands toward the sequencer
  knightCmd_t cmd;
  logic cmdValid;
  logic cmdReady;

  // Answer bytes toward the transmitter
  respCode_t resp;
  logic respValid;
  logic respReady;

  //////////////////////////////////////////////////////////////////////
  // Command path from rx line to tx line
  //////////////////////////////////////////////////////////////////////

  uartRx u_uartRx (
    .clk(clk), .rstN(rstN), .rx(rx), .rxByte(rxByte), .rxValid(rxValid)
  );

  cmdFramer u_cmdFramer (
    .clk(clk), .rstN(rstN), .rxByte(rxByte), .rxValid(rxValid),
    .cmd(cmd), .cmdValid(cmdValid), .cmdReady(cmdReady)
  );

  moveSequencer u_moveSequencer (
    .clk(clk), .rstN(rstN), .cmd(cmd), .cmdValid(cmdValid), .cmdReady(cmdReady),
    .resp(resp), .respValid(respValid), .respReady(respReady),
    .pos(pos), .busy(busy)
  );

  uartTx u_uartTx (
    .clk(clk), .rstN(rstN), .resp(resp), .respValid(respValid),
    .respReady(respReady), .tx(tx)
  );

endmodule

// File: tb/knightTour_props.sv
`timescale 1ns/100ps
`include "knightTour_cfg.svh"

module knightTour_props import knightCmdPkg::*; (
  input logic clk,
  input logic rstN,
  input knightCmd_t cmd,
  input logic cmdValid,
  input logic cmdReady,
  input respCode_t resp,
  input logic respValid,
  input logic respReady,
  input boardPos_t pos
);

  // A waiting command keeps its valid and its contents
  cmdHeldA: assert property (@(posedge clk) disable iff (!rstN)
    cmdValid && !cmdReady |=> cmdValid && $stable(cmd))
    else $error("cmd changed or dropped before cmdReady");

  // The answer stays offered until the transmitter takes it
  respHeldA: assert property (@(posedge clk) disable iff (!rstN)
    respValid && !respReady |=> respValid && $stable(resp))
    else $error("resp changed or dropped before respReady");

  // Both coordinates stay on the board
  posRangeA: assert property (@(posedge clk) disable iff (!rstN)
    pos.x < `BOARD_SIZE && pos.y < `BOARD_SIZE)
    else $error("pos left the board");

endmodule

bind moveSequencer knightTour_props u_props (
  .clk(clk), .rstN(rstN), .cmd(cmd), .cmdValid(cmdValid), .cmdReady(cmdReady),
  .resp(resp), .respValid(respValid), .respReady(respReady), .pos(pos)
);

// File: tb/knightTour_tb.sv
`timescale 1ns/100ps
`include "knightTour_cfg.svh"

module knightTour_tb import knightSerialPkg::*, knightCmdPkg::*; ();

  // Worst wait for an answer covers sending, calibration and the longest move
  localparam int RespLimit = 20 * `BAUD_DIV + 16 * `SQUARE_CYCLES + `CAL_CYCLES + 100;
  // About 60 commands run, each bounded by two characters in, one out and a move
  localparam int NumCmds = 60;
  localparam int CmdCycles = 30 * `BAUD_DIV + `CAL_CYCLES + 4 * `SQUARE_CYCLES;
  localparam int WatchdogCycles = 2 * (NumCmds * CmdCycles + 80 * `BAUD_DIV) + 100;

  logic clk = 1'b0;
  logic rstN;
  logic rx;
  logic tx;
  boardPos_t pos;
  logic busy;

  logic [15:0] lfsr = 16'd29;
  boardPos_t modelPos = POS_HOME;
  logic modelCal = 1'b0;
  logic busySeen = 1'b0;
  int errCount = 0;
  int checkCount = 0;
  int testCount = 0;
  int testFails = 0;
  int testErrStart = 0;

  knightTour u_knightTour (.clk(clk), .rstN(rstN), .rx(rx), .tx(tx), .pos(pos), .busy(busy));

  always #4 clk = ~clk;

  // Busy is watched on the falling edge so calibration can be confirmed later
  always @(negedge clk) begin
    if (busy === 1'b1) busySeen = 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////
  // Random numbers and the remote station
  ////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step for every bit taken
  task automatic randBits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      val = {val[14:0], lfsr[0]};
    end
  endtask

  task automatic driveBit(input logic b);
    @(posedge clk);
    #1 rx = b;
    repeat (`BAUD_DIV - 1) @(posedge clk);
  endtask

  task automatic sendByte(input serialByte_t b);
    driveBit(START_BIT);
    for (int i = 0; i < 8; i++) driveBit(b[i]);
    driveBit(STOP_BIT);
  endtask

  // The high byte goes first
  task automatic sendCmd(input knightCmd_t c);
    sendByte(c[15:8]);
    sendByte(c[7:0]);
  endtask

  // Falling edges give stable samples, and each bit is read at its centre
  task automatic recvByte(output serialByte_t b, output logic ok);
    int waited;
    waited = 0;
    ok = 1'b0;
    b = 'x;
    @(negedge clk);
    while (tx !== START_BIT && waited < RespLimit) begin
      @(negedge clk);
      waited++;
    end
    if (tx !== START_BIT) begin
      errCount++;
      $display("Error at %0t ns: no answer byte started on tx", $time);
    end else begin
      repeat (`BAUD_DIV / 2) @(negedge clk);
      for (int i = 0; i < 8; i++) begin
        repeat (`BAUD_DIV) @(negedge clk);
        b[i] = tx;
      end
      repeat (`BAUD_DIV) @(negedge clk);
      ok = (tx === STOP_BIT);
      if (!ok) begin
        errCount++;
        $display("Error at %0t ns: answer byte on tx had a low stop bit", $time);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Board model and compare tasks
  ////////////////////////////////////////////////////////////////////////

  // Calibrate always succeeds, a move needs every rule satisfied
  task automatic modelCmd(input knightCmd_t c, output respCode_t expResp);
    int dx;
    int dy;
    int nx;
    int ny;
    logic headOk;
    dx = 0;
    dy = 0;
    headOk = 1'b1;
    if (c.heading == HEAD_NORTH) dy = 1;
    else if (c.heading == HEAD_SOUTH) dy = -1;
    else if (c.heading == HEAD_WEST) dx = -1;
    else if (c.heading == HEAD_EAST) dx = 1;
    else headOk = 1'b0;
    nx = int'(modelPos.x) + dx * int'(c.squares);
    ny = int'(modelPos.y) + dy * int'(c.squares);
    if (c.op == OP_CALIBRATE) begin
      modelCal = 1'b1;
      expResp = RESP_ACK;
    end else if (c.op == OP_MOVE && modelCal && headOk && c.squares != 0 &&
                 nx >= 0 && nx < `BOARD_SIZE && ny >= 0 && ny < `BOARD_SIZE) begin
      modelPos = '{x: nx[2:0], y: ny[2:0]};
      expResp = RESP_ACK;
    end else begin
      expResp = RESP_NACK;
    end
  endtask

  task automatic checkResp(input respCode_t got, input respCode_t exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("Fail at %0t ns: resp is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic checkPos(input boardPos_t got, input boardPos_t exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("Fail at %0t ns: pos is (%0d,%0d), expected (%0d,%0d)",
               $time, got.x, got.y, exp.x, exp.y);
    end
  endtask

  // Sends one command, waits for its answer and compares against the model
  task automatic runCmd(input knightCmd_t c);
    respCode_t expResp;
    serialByte_t got;
    logic ok;
    modelCmd(c, expResp);
    fork
      sendCmd(c);
      recvByte(got, ok);
    join
    if (ok) checkResp(got, expResp);
    checkPos(pos, modelPos);
  endtask

  task automatic randomCmd(output knightCmd_t c);
    logic [15:0] r;
    randBits(2, r);
    if (r[1:0] == 2'd0) c.op = OP_CALIBRATE;
    else if (r[1:0] != 2'd3) c.op = OP_MOVE;
    else begin
      randBits(4, r);
      c.op = r[3:0];
    end
    // Half the headings are legal, the rest are raw bytes
    randBits(1, r);
    if (r[0]) begin
      randBits(2, r);
      case (r[1:0])
        2'd0: c.heading = HEAD_NORTH;
        2'd1: c.heading = HEAD_WEST;
        2'd2: c.heading = HEAD_SOUTH;
        default: c.heading = HEAD_EAST;
      endcase
    end else begin
      randBits(8, r);
      c.heading = r[7:0];
    end
    randBits(2, r);
    c.squares = {2'b00, r[1:0]};
  endtask

  task automatic endTest(input string name);
    testCount++;
    if (errCount == testErrStart) begin
      $display("Test %0d %s: ok", testCount, name);
    end else begin
      testFails++;
      $display("Test %0d %s: %0d errors", testCount, name, errCount - testErrStart);
    end
    testErrStart = errCount;
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////

  initial begin
    knightCmd_t c;
    logic txQuiet;
    rstN = 1'b0;
    rx = LINE_IDLE;
    repeat (8) @(posedge clk);
    #1 rstN = 1'b1;

    // Position must not move while uncalibrated
    runCmd('{op: OP_MOVE, heading: HEAD_WEST, squares: 4'd1});
    checkPos(pos, POS_HOME);
    endTest("move before calibrate");

    busySeen = 1'b0;
    runCmd('{op: OP_CALIBRATE, heading: HEAD_NORTH, squares: 4'd0});
    if (!busySeen) begin
      errCount++;
      $display("Error at %0t ns: busy never went high during calibration", $time);
    end
    endTest("calibrate");

    runCmd('{op: OP_MOVE, heading: HEAD_WEST, squares: 4'd1});
    checkPos(pos, '{x: 3'd1, y: 3'd2});
    runCmd('{op: OP_MOVE, heading: HEAD_EAST, squares: 4'd2});
    runCmd('{op: OP_MOVE, heading: HEAD_NORTH, squares: 4'd2});
    runCmd('{op: OP_MOVE, heading: HEAD_SOUTH, squares: 4'd3});
    endTest("legal moves");

    // Off board, zero distance, bad heading, bad opcode
    runCmd('{op: OP_MOVE, heading: HEAD_NORTH, squares: 4'd4});
    runCmd('{op: OP_MOVE, heading: HEAD_EAST, squares: 4'd0});
    runCmd('{op: OP_MOVE, heading: 8'h12, squares: 4'd1});
    runCmd('{op: 4'h7, heading: HEAD_WEST, squares: 4'd1});
    endTest("illegal commands");

    for (int i = 0; i < 40; i++) begin
      randomCmd(c);
      runCmd(c);
    end
    endTest("random commands");

    // A lone high byte must be dropped and produce no answer
    sendByte(8'h43);
    txQuiet = 1'b1;
    repeat (50 * `BAUD_DIV) begin
      @(negedge clk);
      if (tx !== LINE_IDLE) txQuiet = 1'b0;
    end
    if (!txQuiet) begin
      errCount++;
      $display("Error at %0t ns: a lone command byte drew an answer on tx", $time);
    end
    // Pick a direction with room to land so that a stale high byte would draw a NACK
    if (modelPos.x < `BOARD_SIZE - 1) begin
      c = '{op: OP_MOVE, heading: HEAD_EAST, squares: 4'd1};
    end else begin
      c = '{op: OP_MOVE, heading: HEAD_WEST, squares: 4'd1};
    end
    runCmd(c);
    endTest("lone byte discarded");

    $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             testCount, testFails, checkCount, errCount);
    if (errCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Ends a run that never reaches the report
  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Error: watchdog expired after %0d cycles", WatchdogCycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: knightTour.f
+incdir+src
src/knightSerialPkg.sv
src/knightCmdPkg.sv
src/uartRx.sv
src/uartTx.sv
src/cmdFramer.sv
src/moveSequencer.sv
src/knightTour.sv
tb/knightTour_props.sv
tb/knightTour_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = knightTour_tb
FILELIST = knightTour.f
OBJDIR   = obj_dir
PASS_MSG = SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
